// ==== ex_pkg.sv ====
// shared widths, operation codes and exception bit positions
// stage bundles for decode, memory, data cache and forwarding
`default_nettype none

package ex_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [3:0]  alu_op_t;
    typedef logic [1:0]  wb_src_t;
    typedef logic [1:0]  mem_size_t;
    typedef logic [3:0]  wstrb_t;
    typedef logic [19:0] excep_vec_t;

    localparam alu_op_t ALU_ADD  = 4'd0;
    localparam alu_op_t ALU_SUB  = 4'd1;
    localparam alu_op_t ALU_AND  = 4'd2;
    localparam alu_op_t ALU_OR   = 4'd3;
    localparam alu_op_t ALU_XOR  = 4'd4;
    localparam alu_op_t ALU_SLL  = 4'd5;
    localparam alu_op_t ALU_SRL  = 4'd6;
    localparam alu_op_t ALU_SRA  = 4'd7;
    localparam alu_op_t ALU_SLT  = 4'd8;
    localparam alu_op_t ALU_SLTU = 4'd9;
    localparam alu_op_t ALU_MUL  = 4'd10;

    // write-back source, any other code writes zero
    localparam wb_src_t WB_ID = 2'd0;
    localparam wb_src_t WB_LO = 2'd1;
    localparam wb_src_t WB_HI = 2'd2;

    localparam mem_size_t SIZE_BYTE = 2'd0;
    localparam mem_size_t SIZE_HALF = 2'd1;
    localparam mem_size_t SIZE_WORD = 2'd2;

    // misaligned data address
    localparam int ALE_BIT = 8;

    typedef enum logic {IDLE, BUSY} mul_state_e;

    typedef struct packed {
        word_t      pc;
        alu_op_t    alu_op;
        word_t      oper1;
        word_t      oper2;
        wb_src_t    wb_src;
        logic       mem_req;
        logic       mem_we;
        logic       op_sb;
        logic       op_sh;
        word_t      store_data;
        // result only known in mem or wb
        logic       late_result;
        logic       regs_we;
        reg_addr_t  regs_waddr;
        word_t      regs_wdata;
        logic       excep_en;
        excep_vec_t excep_type;
    } id_ex_bus_t;

    typedef struct packed {
        word_t      pc;
        logic       regs_we;
        reg_addr_t  regs_waddr;
        word_t      regs_wdata;
        logic       late_result;
        logic       mem_req;
        word_t      mem_addr;
        logic       excep_en;
        excep_vec_t excep_type;
    } ex_mem_bus_t;

    typedef struct packed {
        logic      req;
        logic      we;
        mem_size_t size;
        wstrb_t    wstrb;
        word_t     addr;
        word_t     wdata;
    } data_req_t;

    typedef struct packed {
        logic      regs_we;
        reg_addr_t regs_waddr;
        word_t     regs_wdata;
        logic      dr_stall;
    } forward_t;

endpackage

`default_nettype wire

// ==== ex_pipe_reg.sv ====
// decode to execute latch
// holds the valid bit and the instruction bundle
`timescale 1ns/1ps
`default_nettype none

module ex_pipe_reg (
    input  wire                logic clk,
    input  wire                logic reset_i,
    input  wire                logic allowin_i,
    input  wire                logic flush_i,
    input  wire                logic in_valid_i,
    input  ex_pkg::id_ex_bus_t in_bus_i,
    output logic               valid_o,
    output ex_pkg::id_ex_bus_t bus_o
);

    logic               valid_q;
    ex_pkg::id_ex_bus_t bus_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            valid_q <= 1'b0;
        end else if (flush_i) begin
            // pipeline flush drops whatever is held
            valid_q <= 1'b0;
        end else if (allowin_i) begin
            valid_q <= in_valid_i;
        end
    end

    // payload only moves with allowin
    always_ff @(posedge clk) begin
        if (allowin_i) begin
            bus_q <= in_bus_i;
        end
    end

    assign valid_o = valid_q;
    assign bus_o   = bus_q;

    // an empty stage is always open to decode
    empty_allows_in: assert property (
        @(posedge clk) disable iff (reset_i)
        !valid_q |-> allowin_i
    );

endmodule

`default_nettype wire

// ==== ex_alu.sv ====
// arithmetic/logic unit for the execute stage
// single-cycle ops plus a fixed latency multiply FSM
`timescale 1ns/1ps
`default_nettype none

module ex_alu #(
    parameter int MUL_CYCLES = 3
) (
    input  wire             logic clk,
    input  wire             logic reset_i,
    input  wire             logic start_i,
    input  ex_pkg::alu_op_t op_i,
    input  ex_pkg::word_t   oper1_i,
    input  ex_pkg::word_t   oper2_i,
    input  wire             logic accept_i,
    output logic            complete_o,
    output ex_pkg::word_t   result_lo_o,
    output ex_pkg::word_t   result_hi_o
);
    import ex_pkg::*;

    localparam int CNT_W = (MUL_CYCLES > 1) ? $clog2(MUL_CYCLES) : 1;
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(MUL_CYCLES - 1);

    mul_state_e       state_q;
    logic [CNT_W-1:0] cnt_q;
    logic [63:0]      product_q;
    word_t            alu_res;
    logic             is_mul;
    logic             mul_done;

    assign is_mul   = (op_i == ALU_MUL);
    assign mul_done = (state_q == BUSY) && (cnt_q == CNT_LAST);

    always_comb begin
        case (op_i)
            ALU_ADD:  alu_res = oper1_i + oper2_i;
            ALU_SUB:  alu_res = oper1_i - oper2_i;
            ALU_AND:  alu_res = oper1_i & oper2_i;
            ALU_OR:   alu_res = oper1_i | oper2_i;
            ALU_XOR:  alu_res = oper1_i ^ oper2_i;
            ALU_SLL:  alu_res = oper1_i << oper2_i[4:0];
            ALU_SRL:  alu_res = oper1_i >> oper2_i[4:0];
            ALU_SRA:  alu_res = word_t'($signed(oper1_i) >>> oper2_i[4:0]);
            ALU_SLT:  alu_res = {31'b0, $signed(oper1_i) < $signed(oper2_i)};
            ALU_SLTU: alu_res = {31'b0, oper1_i < oper2_i};
            default:  alu_res = '0;
        endcase
    end

    // multiply sequencing
    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (start_i && is_mul) begin
                        state_q <= BUSY;
                        cnt_q   <= '0;
                    end
                end
                BUSY: begin
                    // leave on hand-off, or when the instruction was flushed
                    if (!start_i || (mul_done && accept_i)) begin
                        state_q <= IDLE;
                    end else if (!mul_done) begin
                        cnt_q <= cnt_q + CNT_W'(1);
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == IDLE && start_i && is_mul) begin
            product_q <= 64'(oper1_i) * 64'(oper2_i);
        end
    end

    assign complete_o  = is_mul ? mul_done : 1'b1;
    assign result_lo_o = is_mul ? product_q[31:0] : alu_res;
    assign result_hi_o = is_mul ? product_q[63:32] : '0;

    // multiply result must not show up early
    mul_min_latency: assert property (
        @(posedge clk) disable iff (reset_i)
        (state_q == IDLE && start_i && is_mul) |-> !(complete_o && is_mul) [*MUL_CYCLES]
    );

endmodule

`default_nettype wire

// ==== ex_mem_req.sv ====
// data memory request forming
// size, byte strobes, replicated store data, alignment check
`timescale 1ns/1ps
`default_nettype none

module ex_mem_req (
    input  wire               logic issue_i,
    input  wire               logic commit_i,
    input  wire               logic mem_req_i,
    input  wire               logic mem_we_i,
    input  wire               logic op_sb_i,
    input  wire               logic op_sh_i,
    input  ex_pkg::word_t     addr_i,
    input  ex_pkg::word_t     store_data_i,
    output ex_pkg::data_req_t data_req_o,
    output logic              align_err_o
);
    import ex_pkg::*;

    logic      req;
    logic      we;
    word_t     addr;
    mem_size_t size;
    wstrb_t    strb;
    word_t     wdata;

    // address only meaningful for memory ops
    assign addr = mem_req_i ? addr_i : '0;

    assign req = mem_req_i & issue_i;
    assign we  = mem_we_i & commit_i;

    always_comb begin
        if (op_sb_i) begin
            size  = SIZE_BYTE;
            strb  = 4'b0001 << addr[1:0];
            wdata = {4{store_data_i[7:0]}};
        end else if (op_sh_i) begin
            size  = SIZE_HALF;
            strb  = addr[1] ? 4'b1100 : 4'b0011;
            wdata = {2{store_data_i[15:0]}};
        end else begin
            size  = SIZE_WORD;
            strb  = 4'b1111;
            wdata = store_data_i;
        end
    end

    // odd half address, or word address off a 4-byte boundary
    assign align_err_o = req && ((op_sh_i && addr[0])
                              || (!op_sh_i && !op_sb_i && (addr[1:0] != 2'b00)));

    assign data_req_o.req   = req;
    assign data_req_o.we    = we;
    assign data_req_o.size  = size;
    // strobes only for a write that goes out
    assign data_req_o.wstrb = we ? strb : '0;
    assign data_req_o.addr  = addr;
    assign data_req_o.wdata = wdata;

endmodule

`default_nettype wire

// ==== ex_ctrl.sv ====
// execute stage control: gating, handshake, exception merge
// write-back select and forwarding info for decode
`timescale 1ns/1ps
`default_nettype none

module ex_ctrl (
    input  wire                 logic valid_i,
    input  ex_pkg::id_ex_bus_t  bus_i,
    input  wire                 logic mem_allowin_i,
    input  wire                 logic mem_stall_i,
    input  wire                 logic excep_flush_i,
    input  wire                 logic addr_ok_i,
    input  wire                 logic req_i,
    input  wire                 logic align_err_i,
    input  wire                 logic alu_complete_i,
    input  ex_pkg::word_t       result_lo_i,
    input  ex_pkg::word_t       result_hi_i,
    output logic                issue_o,
    output logic                commit_o,
    output logic                alu_start_o,
    output logic                allowin_o,
    output logic                to_mem_valid_o,
    output ex_pkg::ex_mem_bus_t mem_bus_o,
    output ex_pkg::forward_t    forward_o
);
    import ex_pkg::*;

    logic       base_valid;
    logic       excep_en;
    logic       ready_go;
    logic       regs_we;
    word_t      regs_wdata;
    excep_vec_t excep_type;

    assign base_valid = valid_i & ~excep_flush_i;
    assign excep_en   = bus_i.excep_en | align_err_i;

    // request may go out once mem can take it
    assign issue_o     = base_valid & mem_allowin_i;
    // state changes need no stall and no exception
    assign commit_o    = base_valid & ~mem_stall_i & ~excep_en;
    assign alu_start_o = base_valid;

    // memory ops wait for addr_ok, others for the alu
    assign ready_go = mem_stall_i ? 1'b0
                    : bus_i.mem_req ? (req_i & addr_ok_i)
                    : alu_complete_i;

    assign allowin_o      = !valid_i || (ready_go && mem_allowin_i);
    assign to_mem_valid_o = valid_i && ready_go;

    always_comb begin
        excep_type          = bus_i.excep_type;
        excep_type[ALE_BIT] = bus_i.excep_type[ALE_BIT] | (align_err_i & base_valid);
    end

    always_comb begin
        case (bus_i.wb_src)
            WB_ID:   regs_wdata = bus_i.regs_wdata;
            WB_LO:   regs_wdata = result_lo_i;
            WB_HI:   regs_wdata = result_hi_i;
            default: regs_wdata = '0;
        endcase
    end

    assign regs_we = bus_i.regs_we & commit_o;

    assign mem_bus_o.pc          = bus_i.pc;
    assign mem_bus_o.regs_we     = regs_we;
    assign mem_bus_o.regs_waddr  = bus_i.regs_waddr;
    assign mem_bus_o.regs_wdata  = regs_wdata;
    assign mem_bus_o.late_result = bus_i.late_result;
    assign mem_bus_o.mem_req     = req_i;
    assign mem_bus_o.mem_addr    = bus_i.mem_req ? result_lo_i : '0;
    assign mem_bus_o.excep_en    = excep_en & base_valid;
    assign mem_bus_o.excep_type  = excep_type;

    assign forward_o.regs_we    = regs_we;
    assign forward_o.regs_waddr = bus_i.regs_waddr;
    assign forward_o.regs_wdata = regs_wdata;
    // decode has to wait for a value not ready here
    assign forward_o.dr_stall   = bus_i.late_result & valid_i;

endmodule

`default_nettype wire

// ==== ex_stage.sv ====
// execute stage top level
// latch, alu, memory request and control instances
`timescale 1ns/1ps
`default_nettype none

module ex_stage #(
    parameter int MUL_CYCLES = 3
) (
    input  wire                 logic clk,
    input  wire                 logic reset_i,
    input  wire                 logic id_valid_i,
    input  ex_pkg::id_ex_bus_t  id_bus_i,
    output logic                ex_allowin_o,
    input  wire                 logic mem_allowin_i,
    input  wire                 logic mem_stall_i,
    input  wire                 logic excep_flush_i,
    input  wire                 logic data_addr_ok_i,
    output logic                ex_to_mem_valid_o,
    output ex_pkg::ex_mem_bus_t ex_mem_bus_o,
    output ex_pkg::data_req_t   data_req_o,
    output ex_pkg::forward_t    forward_o
);
    import ex_pkg::*;

    logic       ex_valid;
    id_ex_bus_t ex_bus;
    logic       issue;
    logic       commit;
    logic       alu_start;
    logic       alu_complete;
    logic       align_err;
    word_t      result_lo;
    word_t      result_hi;

    ex_pipe_reg u_pipe_reg (
        .clk        (clk),
        .reset_i    (reset_i),
        .allowin_i  (ex_allowin_o),
        .flush_i    (excep_flush_i),
        .in_valid_i (id_valid_i),
        .in_bus_i   (id_bus_i),
        .valid_o    (ex_valid),
        .bus_o      (ex_bus)
    );

    // allowin doubles as the alu hand-off while valid
    ex_alu #(
        .MUL_CYCLES (MUL_CYCLES)
    ) u_alu (
        .clk         (clk),
        .reset_i     (reset_i),
        .start_i     (alu_start),
        .op_i        (ex_bus.alu_op),
        .oper1_i     (ex_bus.oper1),
        .oper2_i     (ex_bus.oper2),
        .accept_i    (ex_allowin_o),
        .complete_o  (alu_complete),
        .result_lo_o (result_lo),
        .result_hi_o (result_hi)
    );

    ex_mem_req u_mem_req (
        .issue_i      (issue),
        .commit_i     (commit),
        .mem_req_i    (ex_bus.mem_req),
        .mem_we_i     (ex_bus.mem_we),
        .op_sb_i      (ex_bus.op_sb),
        .op_sh_i      (ex_bus.op_sh),
        .addr_i       (result_lo),
        .store_data_i (ex_bus.store_data),
        .data_req_o   (data_req_o),
        .align_err_o  (align_err)
    );

    ex_ctrl u_ctrl (
        .valid_i        (ex_valid),
        .bus_i          (ex_bus),
        .mem_allowin_i  (mem_allowin_i),
        .mem_stall_i    (mem_stall_i),
        .excep_flush_i  (excep_flush_i),
        .addr_ok_i      (data_addr_ok_i),
        .req_i          (data_req_o.req),
        .align_err_i    (align_err),
        .alu_complete_i (alu_complete),
        .result_lo_i    (result_lo),
        .result_hi_i    (result_hi),
        .issue_o        (issue),
        .commit_o       (commit),
        .alu_start_o    (alu_start),
        .allowin_o      (ex_allowin_o),
        .to_mem_valid_o (ex_to_mem_valid_o),
        .mem_bus_o      (ex_mem_bus_o),
        .forward_o      (forward_o)
    );

endmodule

`default_nettype wire

// ==== tb_ex_stage.sv ====
// directed testbench for the execute stage
// alu ops, multiply latency, store requests, alignment and back-pressure
`timescale 1ns/1ps
`default_nettype none

module tb_ex_stage;
    import ex_pkg::*;

    localparam int MUL_CYCLES = 3;
    // roughly 100 cycles of tests, with ample margin
    localparam int CYCLE_LIMIT = 400;
    localparam int WAIT_LIMIT = 16;

    logic        clk;
    logic        reset_i;
    logic        id_valid_i;
    id_ex_bus_t  id_bus_i;
    logic        ex_allowin_o;
    logic        mem_allowin_i;
    logic        mem_stall_i;
    logic        excep_flush_i;
    logic        data_addr_ok_i;
    logic        ex_to_mem_valid_o;
    ex_mem_bus_t ex_mem_bus_o;
    data_req_t   data_req_o;
    forward_t    forward_o;

    int mismatches = 0;
    int failures = 0;
    int cycle_count = 0;

    ex_stage #(.MUL_CYCLES(MUL_CYCLES)) dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    initial begin
        wait (cycle_count >= CYCLE_LIMIT);
        $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("TESTBENCH FAILED");
        $finish;
    end

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %h, expected %h", $time, name, got, exp);
            mismatches++;
        end
    endtask

    task automatic check_strb(input string name, input wstrb_t got, input wstrb_t exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %b, expected %b", $time, name, got, exp);
            mismatches++;
        end
    endtask

    task automatic check_size(input string name, input mem_size_t got, input mem_size_t exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %0d, expected %0d", $time, name, got, exp);
            mismatches++;
        end
    endtask

    task automatic check_reg(input string name, input reg_addr_t got, input reg_addr_t exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %0d, expected %0d", $time, name, got, exp);
            mismatches++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %b, expected %b", $time, name, got, exp);
            mismatches++;
        end
    endtask

    task automatic report_failure(input string what);
        $display("ERROR at %0t: %s", $time, what);
        failures++;
    endtask

    // reference results straight from the op definitions
    function automatic word_t model_alu(input alu_op_t op, input word_t a, input word_t b);
        case (op)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a - b;
            ALU_XOR:  return a ^ b;
            ALU_SLL:  return a << b[4:0];
            ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
            default:  return '0;
        endcase
    endfunction

    function automatic id_ex_bus_t alu_bus(input alu_op_t op, input word_t a, input word_t b,
                                           input wb_src_t src);
        id_ex_bus_t bus;
        bus            = '0;
        bus.pc         = 32'h1c00_0100;
        bus.alu_op     = op;
        bus.oper1      = a;
        bus.oper2      = b;
        bus.wb_src     = src;
        bus.regs_we    = 1'b1;
        bus.regs_waddr = 5'd7;
        return bus;
    endfunction

    // address comes out of the alu as addr + 0
    function automatic id_ex_bus_t store_bus(input logic sb, input logic sh, input word_t addr,
                                             input word_t data);
        id_ex_bus_t bus;
        bus            = alu_bus(ALU_ADD, addr, '0, WB_LO);
        bus.mem_req    = 1'b1;
        bus.mem_we     = 1'b1;
        bus.op_sb      = sb;
        bus.op_sh      = sh;
        bus.store_data = data;
        bus.regs_we    = 1'b0;
        return bus;
    endfunction

    // called 2 ns after a rising edge with the stage empty
    task automatic issue(input id_ex_bus_t bus);
        id_bus_i   = bus;
        id_valid_i = 1'b1;
        @(posedge clk);
        #2;
        id_valid_i = 1'b0;
    endtask

    // returns at the falling edge where the stage hands its result on
    task automatic wait_done(output int low_cycles);
        low_cycles = 0;
        @(negedge clk);
        while (!ex_to_mem_valid_o && low_cycles < WAIT_LIMIT) begin
            low_cycles++;
            @(negedge clk);
        end
        if (!ex_to_mem_valid_o) begin
            report_failure("ex_to_mem_valid_o never rose for the issued instruction");
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic check_reset();
        @(negedge clk);
        check_bit("ex_allowin_o", ex_allowin_o, 1'b1);
        check_bit("ex_to_mem_valid_o", ex_to_mem_valid_o, 1'b0);
        check_bit("data_req_o.req", data_req_o.req, 1'b0);
        check_bit("data_req_o.we", data_req_o.we, 1'b0);
        check_bit("forward_o.regs_we", forward_o.regs_we, 1'b0);
        next_cycle();
    endtask

    task automatic test_alu_ops();
        alu_op_t ops [5] = '{ALU_ADD, ALU_SUB, ALU_XOR, ALU_SLL, ALU_SLTU};
        word_t   a;
        word_t   b;
        int      lat;
        for (int rep = 0; rep < 4; rep++) begin
            foreach (ops[i]) begin
                a = $urandom();
                b = $urandom();
                issue(alu_bus(ops[i], a, b, WB_LO));
                wait_done(lat);
                if (lat != 0) begin
                    report_failure($sformatf("alu op %0d was not done in its first cycle", ops[i]));
                end
                check_word("ex_mem_bus_o.regs_wdata", ex_mem_bus_o.regs_wdata,
                           model_alu(ops[i], a, b));
                check_word("forward_o.regs_wdata", forward_o.regs_wdata, model_alu(ops[i], a, b));
                check_bit("ex_mem_bus_o.regs_we", ex_mem_bus_o.regs_we, 1'b1);
                check_bit("forward_o.regs_we", forward_o.regs_we, 1'b1);
                check_reg("ex_mem_bus_o.regs_waddr", ex_mem_bus_o.regs_waddr, 5'd7);
                check_reg("forward_o.regs_waddr", forward_o.regs_waddr, 5'd7);
                check_word("ex_mem_bus_o.pc", ex_mem_bus_o.pc, 32'h1c00_0100);
                next_cycle();
            end
        end
    endtask

    task automatic test_multiply();
        word_t       a;
        word_t       b;
        logic [63:0] prod;
        int          lat;
        for (int k = 0; k < 2; k++) begin
            a    = $urandom();
            b    = $urandom();
            prod = {32'b0, a} * {32'b0, b};
            issue(alu_bus(ALU_MUL, a, b, (k == 0) ? WB_HI : WB_LO));
            wait_done(lat);
            if (lat != MUL_CYCLES) begin
                report_failure($sformatf("multiply latency was %0d cycles, not %0d", lat,
                                         MUL_CYCLES));
            end
            check_word("ex_mem_bus_o.regs_wdata", ex_mem_bus_o.regs_wdata,
                       (k == 0) ? prod[63:32] : prod[31:0]);
            next_cycle();
        end
    endtask

    task automatic store_and_check(input logic sb, input logic sh, input logic [1:0] off);
        word_t     addr;
        word_t     d;
        wstrb_t    exp_strb;
        mem_size_t exp_size;
        word_t     exp_data;
        int        lat;
        addr      = $urandom();
        addr[1:0] = off;
        d         = $urandom();
        if (sb) begin
            exp_size = SIZE_BYTE;
            exp_data = {d[7:0], d[7:0], d[7:0], d[7:0]};
            case (off)
                2'd0:    exp_strb = 4'b0001;
                2'd1:    exp_strb = 4'b0010;
                2'd2:    exp_strb = 4'b0100;
                default: exp_strb = 4'b1000;
            endcase
        end else if (sh) begin
            exp_size = SIZE_HALF;
            exp_data = {d[15:0], d[15:0]};
            exp_strb = off[1] ? 4'b1100 : 4'b0011;
        end else begin
            exp_size = SIZE_WORD;
            exp_data = d;
            exp_strb = 4'b1111;
        end
        issue(store_bus(sb, sh, addr, d));
        wait_done(lat);
        if (lat != 0) begin
            report_failure("aligned store with addr_ok high did not complete at once");
        end
        check_bit("data_req_o.req", data_req_o.req, 1'b1);
        check_bit("data_req_o.we", data_req_o.we, 1'b1);
        check_size("data_req_o.size", data_req_o.size, exp_size);
        check_strb("data_req_o.wstrb", data_req_o.wstrb, exp_strb);
        check_word("data_req_o.wdata", data_req_o.wdata, exp_data);
        check_word("data_req_o.addr", data_req_o.addr, addr);
        check_bit("ex_mem_bus_o.mem_req", ex_mem_bus_o.mem_req, 1'b1);
        check_word("ex_mem_bus_o.mem_addr", ex_mem_bus_o.mem_addr, addr);
        next_cycle();
    endtask

    task automatic misaligned_store(input logic sh, input logic [1:0] off);
        id_ex_bus_t bus;
        word_t      addr;
        int         lat;
        addr        = $urandom();
        addr[1:0]   = off;
        bus         = store_bus(1'b0, sh, addr, $urandom());
        bus.regs_we = 1'b1;
        issue(bus);
        wait_done(lat);
        check_bit("ex_mem_bus_o.excep_en", ex_mem_bus_o.excep_en, 1'b1);
        check_bit("ex_mem_bus_o.excep_type[ALE_BIT]", ex_mem_bus_o.excep_type[ALE_BIT], 1'b1);
        check_bit("data_req_o.req", data_req_o.req, 1'b1);
        check_bit("data_req_o.we", data_req_o.we, 1'b0);
        check_bit("ex_mem_bus_o.regs_we", ex_mem_bus_o.regs_we, 1'b0);
        next_cycle();
    endtask

    task automatic test_backpressure();
        id_ex_bus_t bus;
        int         lat;
        // held load while memory refuses it
        bus        = store_bus(1'b0, 1'b0, 32'h0000_2000, '0);
        bus.mem_we = 1'b0;
        mem_allowin_i = 1'b0;
        issue(bus);
        repeat (3) begin
            @(negedge clk);
            check_bit("data_req_o.req", data_req_o.req, 1'b0);
            check_bit("ex_allowin_o", ex_allowin_o, 1'b0);
            check_bit("ex_to_mem_valid_o", ex_to_mem_valid_o, 1'b0);
        end
        next_cycle();
        mem_allowin_i = 1'b1;
        wait_done(lat);
        check_bit("data_req_o.req", data_req_o.req, 1'b1);
        next_cycle();
        // stalled store keeps every write enable low
        bus         = store_bus(1'b0, 1'b0, 32'h0000_3000, $urandom());
        bus.regs_we = 1'b1;
        mem_stall_i = 1'b1;
        issue(bus);
        @(negedge clk);
        check_bit("data_req_o.we", data_req_o.we, 1'b0);
        check_bit("ex_mem_bus_o.regs_we", ex_mem_bus_o.regs_we, 1'b0);
        check_bit("forward_o.regs_we", forward_o.regs_we, 1'b0);
        check_bit("ex_to_mem_valid_o", ex_to_mem_valid_o, 1'b0);
        next_cycle();
        mem_stall_i = 1'b0;
        wait_done(lat);
        check_bit("data_req_o.we", data_req_o.we, 1'b1);
        next_cycle();
        bus             = alu_bus(ALU_ADD, $urandom(), $urandom(), WB_LO);
        bus.late_result = 1'b1;
        issue(bus);
        wait_done(lat);
        check_bit("forward_o.dr_stall", forward_o.dr_stall, 1'b1);
        check_bit("ex_mem_bus_o.late_result", ex_mem_bus_o.late_result, 1'b1);
        next_cycle();
        @(negedge clk);
        check_bit("forward_o.dr_stall", forward_o.dr_stall, 1'b0);
        next_cycle();
    endtask

    initial begin
        void'($urandom(20178));
        reset_i        = 1'b1;
        id_valid_i     = 1'b0;
        id_bus_i       = '0;
        mem_allowin_i  = 1'b1;
        mem_stall_i    = 1'b0;
        excep_flush_i  = 1'b0;
        data_addr_ok_i = 1'b1;
        repeat (4) @(posedge clk);
        #2;
        reset_i = 1'b0;
        check_reset();
        test_alu_ops();
        test_multiply();
        for (int off = 0; off < 4; off++) begin
            store_and_check(1'b1, 1'b0, off[1:0]);
        end
        store_and_check(1'b0, 1'b1, 2'd0);
        store_and_check(1'b0, 1'b1, 2'd2);
        store_and_check(1'b0, 1'b0, 2'd0);
        misaligned_store(1'b1, 2'd1);
        misaligned_store(1'b1, 2'd3);
        for (int off = 1; off < 4; off++) begin
            misaligned_store(1'b0, off[1:0]);
        end
        test_backpressure();
        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
ex_pkg.sv
ex_pipe_reg.sv
ex_alu.sv
ex_mem_req.sv
ex_ctrl.sv
ex_stage.sv
tb_ex_stage.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the execute stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_ex_stage -f sources.f -o sim_ex_stage || exit 1
out=$(./obj_dir/sim_ex_stage)
echo "$out"
echo "$out" | grep -q "TESTBENCH PASSED" && exit 0 || exit 1
